// File: src/rv_pkg.sv
package rv_pkg;

    // datapath widths
    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;   // architectural register count, x0 included

    typedef logic [XLEN-1:0] data_t;    // register or result value
    typedef logic [XLEN-1:0] instr_t;   // one instruction word
    typedef logic [4:0]      reg_idx_t; // register number
    typedef logic [4:0]      shamt_t;   // shift amount, low 5 bits only on rv32

    // major opcodes, instr[6:0]
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // funct7 codes
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001; // M extension group
    localparam logic [6:0] FUNCT7_ALT    = 7'b0100000; // sub and sra

    // immediate forms share the register encodings, use_imm picks the operand
    typedef enum logic [4:0] {
        OP_ADD,
        OP_SUB,
        OP_SLL,
        OP_SLT,
        OP_SLTU,
        OP_XOR,
        OP_SRL,
        OP_SRA,
        OP_OR,
        OP_AND,
        OP_LUI,
        OP_MUL,
        OP_MULH,
        OP_MULHSU,
        OP_MULHU,
        OP_ILLEGAL
    } alu_op_e;

    typedef struct packed {
        alu_op_e  op;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        data_t    imm;     // sign extended I-imm, shamt or U-imm
        logic     use_imm; // second operand is imm instead of rs2
    } decoded_t;

    typedef struct packed {
        reg_idx_t rd;
        data_t    value;
        logic     we;      // low for illegal encodings
    } result_t;

endpackage

// File: src/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::instr_t   instr,
    input  logic             req,
    input  logic             busy,      // result pending on the handshake
    output rv_pkg::decoded_t dec,
    output logic             dec_valid
);

    rv_pkg::instr_t   instr_q;    // captured instruction
    logic             cap_valid;  // instr_q loaded last cycle
    logic             taken;      // current request already accepted
    logic             accept;
    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    rv_pkg::shamt_t   shamt;
    rv_pkg::decoded_t dec_d;

    assign accept = req && !busy && !taken; // one accept per req pulse

    assign opcode = instr_q[6:0];
    assign funct3 = instr_q[14:12];
    assign funct7 = instr_q[31:25];
    assign shamt  = instr_q[24:20];

    always_ff @(posedge clk) begin
        if (rst) begin
            taken     <= 1'b0;
            cap_valid <= 1'b0;
            dec_valid <= 1'b0;
        end else begin
            cap_valid <= accept;
            dec_valid <= cap_valid; // one cycle after capture
            if (accept) begin
                taken <= 1'b1;
            end else if (!req) begin
                taken <= 1'b0;      // host finished this request
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) instr_q <= instr;
        if (cap_valid) dec <= dec_d;
    end

    always_comb begin
        dec_d.op      = rv_pkg::OP_ILLEGAL; // anything unmatched stays illegal
        dec_d.rs1     = instr_q[19:15];
        dec_d.rs2     = instr_q[24:20];
        dec_d.rd      = instr_q[11:7];
        dec_d.imm     = {{(rv_pkg::XLEN-12){instr_q[31]}}, instr_q[31:20]};
        dec_d.use_imm = 1'b0;
        case (opcode)
            rv_pkg::OPC_OP_IMM: begin
                dec_d.use_imm = 1'b1;
                case (funct3)
                    3'b000: dec_d.op = rv_pkg::OP_ADD;
                    3'b010: dec_d.op = rv_pkg::OP_SLT;
                    3'b011: dec_d.op = rv_pkg::OP_SLTU; // unsigned compare, imm still sign extended
                    3'b100: dec_d.op = rv_pkg::OP_XOR;
                    3'b110: dec_d.op = rv_pkg::OP_OR;
                    3'b111: dec_d.op = rv_pkg::OP_AND;
                    3'b001: begin
                        dec_d.imm = {{(rv_pkg::XLEN-5){1'b0}}, shamt};
                        if (funct7 == 7'b0) dec_d.op = rv_pkg::OP_SLL;
                    end
                    default: begin // 3'b101, srli or srai by funct7
                        dec_d.imm = {{(rv_pkg::XLEN-5){1'b0}}, shamt};
                        if (funct7 == 7'b0) dec_d.op = rv_pkg::OP_SRL;
                        else if (funct7 == rv_pkg::FUNCT7_ALT) dec_d.op = rv_pkg::OP_SRA;
                    end
                endcase
            end
            rv_pkg::OPC_OP: begin
                if (funct7 == 7'b0) begin
                    case (funct3)
                        3'b000:  dec_d.op = rv_pkg::OP_ADD;
                        3'b001:  dec_d.op = rv_pkg::OP_SLL;
                        3'b010:  dec_d.op = rv_pkg::OP_SLT;
                        3'b011:  dec_d.op = rv_pkg::OP_SLTU;
                        3'b100:  dec_d.op = rv_pkg::OP_XOR;
                        3'b101:  dec_d.op = rv_pkg::OP_SRL;
                        3'b110:  dec_d.op = rv_pkg::OP_OR;
                        default: dec_d.op = rv_pkg::OP_AND;
                    endcase
                end else if (funct7 == rv_pkg::FUNCT7_ALT) begin
                    if (funct3 == 3'b000) dec_d.op = rv_pkg::OP_SUB;
                    else if (funct3 == 3'b101) dec_d.op = rv_pkg::OP_SRA;
                end else if (funct7 == rv_pkg::FUNCT7_MULDIV) begin
                    case (funct3)
                        3'b000:  dec_d.op = rv_pkg::OP_MUL;
                        3'b001:  dec_d.op = rv_pkg::OP_MULH;
                        3'b010:  dec_d.op = rv_pkg::OP_MULHSU;
                        3'b011:  dec_d.op = rv_pkg::OP_MULHU;
                        default: dec_d.op = rv_pkg::OP_ILLEGAL; // div group not supported
                    endcase
                end
            end
            rv_pkg::OPC_LUI: begin
                dec_d.op      = rv_pkg::OP_LUI;
                dec_d.rs1     = '0;
                dec_d.imm     = {instr_q[31:12], 12'b0}; // upper 20 bits, low 12 cleared
                dec_d.use_imm = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: src/rv_multiply.sv
`timescale 1ns/1ps

module rv_multiply #(
    parameter int MUL_STAGES = 2  // at least 1
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          start,
    input  rv_pkg::data_t a,
    input  rv_pkg::data_t b,
    input  logic          a_signed,
    input  logic          b_signed,
    input  logic          high,     // return bits 63:32
    output logic          done,
    output rv_pkg::data_t product
);

    logic signed [rv_pkg::XLEN:0]     a_ext;  // one extra bit carries the sign
    logic signed [rv_pkg::XLEN:0]     b_ext;
    logic signed [2*rv_pkg::XLEN+1:0] full;
    logic [2*rv_pkg::XLEN-1:0]        prod_q [MUL_STAGES];
    logic [MUL_STAGES-1:0]            vld_q;
    logic [MUL_STAGES-1:0]            high_q;

    assign a_ext = {a_signed & a[rv_pkg::XLEN-1], a};
    assign b_ext = {b_signed & b[rv_pkg::XLEN-1], b};
    assign full  = a_ext * b_ext;

    always_ff @(posedge clk) begin
        prod_q[0] <= full[2*rv_pkg::XLEN-1:0];
        high_q[0] <= high;
        for (int i = 1; i < MUL_STAGES; i++) begin
            prod_q[i] <= prod_q[i-1];
            high_q[i] <= high_q[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= start;
            for (int i = 1; i < MUL_STAGES; i++) vld_q[i] <= vld_q[i-1];
        end
    end

    assign done    = vld_q[MUL_STAGES-1];
    assign product = high_q[MUL_STAGES-1] ? prod_q[MUL_STAGES-1][2*rv_pkg::XLEN-1:rv_pkg::XLEN]
                                          : prod_q[MUL_STAGES-1][rv_pkg::XLEN-1:0];

endmodule

// File: src/rv_alu.sv
`timescale 1ns/1ps

module rv_alu #(
    parameter int MUL_STAGES = 2
) (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::decoded_t dec,
    input  logic             dec_valid,
    output rv_pkg::reg_idx_t rs1,
    output rv_pkg::reg_idx_t rs2,
    input  rv_pkg::data_t    rdata1,
    input  rv_pkg::data_t    rdata2,
    output rv_pkg::result_t  wb,
    output logic             wb_valid
);

    rv_pkg::data_t    opb;        // rs2 or immediate
    rv_pkg::shamt_t   sh;
    rv_pkg::data_t    alu_value;
    logic             is_mul;
    logic             mul_start;
    logic             mul_done;
    rv_pkg::data_t    mul_value;
    rv_pkg::reg_idx_t rd_pipe [MUL_STAGES]; // rd travelling beside the multiplier

    assign rs1 = dec.rs1;
    assign rs2 = dec.rs2;

    assign opb = dec.use_imm ? dec.imm : rdata2;
    assign sh  = opb[4:0];  // shifts only look at the low 5 bits

    assign is_mul    = dec.op inside {rv_pkg::OP_MUL, rv_pkg::OP_MULH,
                                      rv_pkg::OP_MULHSU, rv_pkg::OP_MULHU};
    assign mul_start = dec_valid && is_mul;

    always_comb begin
        case (dec.op)
            rv_pkg::OP_ADD:  alu_value = rdata1 + opb;
            rv_pkg::OP_SUB:  alu_value = rdata1 - opb;
            rv_pkg::OP_SLL:  alu_value = rdata1 << sh;
            rv_pkg::OP_SLT:  alu_value = {{(rv_pkg::XLEN-1){1'b0}}, $signed(rdata1) < $signed(opb)};
            rv_pkg::OP_SLTU: alu_value = {{(rv_pkg::XLEN-1){1'b0}}, rdata1 < opb};
            rv_pkg::OP_XOR:  alu_value = rdata1 ^ opb;
            rv_pkg::OP_SRL:  alu_value = rdata1 >> sh;
            rv_pkg::OP_SRA:  alu_value = rv_pkg::data_t'($signed(rdata1) >>> sh);
            rv_pkg::OP_OR:   alu_value = rdata1 | opb;
            rv_pkg::OP_AND:  alu_value = rdata1 & opb;
            rv_pkg::OP_LUI:  alu_value = dec.imm;  // already shifted by decode
            default:         alu_value = '0;       // multiplies and illegal
        endcase
    end

    rv_multiply #(
        .MUL_STAGES(MUL_STAGES)
    ) i_multiply (
        .clk      (clk),
        .rst      (rst),
        .start    (mul_start),
        .a        (rdata1),
        .b        (rdata2),
        .a_signed (dec.op == rv_pkg::OP_MULH || dec.op == rv_pkg::OP_MULHSU),
        .b_signed (dec.op == rv_pkg::OP_MULH),
        .high     (dec.op != rv_pkg::OP_MUL), // mul takes the low word
        .done     (mul_done),
        .product  (mul_value)
    );

    always_ff @(posedge clk) begin
        rd_pipe[0] <= dec.rd;
        for (int i = 1; i < MUL_STAGES; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
        if (mul_done) begin
            wb.rd    <= rd_pipe[MUL_STAGES-1];
            wb.value <= mul_value;
            wb.we    <= 1'b1;
        end else if (dec_valid) begin
            wb.rd    <= dec.rd;
            wb.value <= alu_value;
            wb.we    <= dec.op != rv_pkg::OP_ILLEGAL; // illegal still retires
        end
    end

    always_ff @(posedge clk) begin
        if (rst) wb_valid <= 1'b0;
        else     wb_valid <= (dec_valid && !is_mul) || mul_done;
    end

endmodule

// File: src/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile #(
    parameter int NUM_REGS = rv_pkg::NUM_REGS
) (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    output rv_pkg::data_t    rdata1,
    output rv_pkg::data_t    rdata2,
    input  rv_pkg::result_t  wb,
    input  logic             wb_valid,
    input  logic             req,
    output logic             ack,
    output logic             busy,
    output rv_pkg::result_t  result
);

    rv_pkg::data_t regs [NUM_REGS];

    // x0 reads zero whatever the array holds
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) regs[i] <= '0;
        end else if (wb_valid && wb.we && wb.rd != '0) begin
            regs[wb.rd] <= wb.value;  // writes to x0 dropped
        end
    end

    // retired result, held for the host until the next retire
    always_ff @(posedge clk) begin
        if (wb_valid) begin
            result.rd    <= wb.rd;
            result.value <= (wb.rd == '0) ? '0 : wb.value;
            result.we    <= wb.we;
        end
    end

    // four phase: ack up after retire, down once req is seen low
    always_ff @(posedge clk) begin
        if (rst) begin
            ack  <= 1'b0;
            busy <= 1'b0;
        end else begin
            if (wb_valid) begin
                ack <= 1'b1;
            end else if (!req) begin
                ack <= 1'b0;
            end
            if (wb_valid) begin
                busy <= 1'b1;           // blocks a new accept until ack falls
            end else if (ack && !req) begin
                busy <= 1'b0;           // same edge ack clears
            end
        end
    end

endmodule

// File: src/rv_core.sv
`timescale 1ns/1ps

module rv_core #(
    parameter int MUL_STAGES = 2,
    parameter int NUM_REGS   = rv_pkg::NUM_REGS
) (
    input  logic            clk,
    input  logic            rst,
    input  rv_pkg::instr_t  instr,
    input  logic            req,
    output logic            ack,
    output rv_pkg::result_t result
);

    rv_pkg::decoded_t dec;
    logic             dec_valid;
    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t rs2;
    rv_pkg::data_t    rdata1;
    rv_pkg::data_t    rdata2;
    rv_pkg::result_t  wb;
    logic             wb_valid;
    logic             busy;

    // capture and decode, two registers deep
    rv_decode i_decode (
        .clk       (clk),
        .rst       (rst),
        .instr     (instr),
        .req       (req),
        .busy      (busy),
        .dec       (dec),
        .dec_valid (dec_valid)
    );

    rv_alu #(
        .MUL_STAGES(MUL_STAGES)
    ) i_alu (
        .clk       (clk),
        .rst       (rst),
        .dec       (dec),
        .dec_valid (dec_valid),
        .rs1       (rs1),
        .rs2       (rs2),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .wb        (wb),
        .wb_valid  (wb_valid)
    );

    rv_regfile #(
        .NUM_REGS(NUM_REGS)
    ) i_regfile (
        .clk      (clk),
        .rst      (rst),
        .rs1      (rs1),
        .rs2      (rs2),
        .rdata1   (rdata1),
        .rdata2   (rdata2),
        .wb       (wb),
        .wb_valid (wb_valid),
        .req      (req),
        .ack      (ack),
        .busy     (busy),
        .result   (result)
    );

endmodule

// File: testbench/rv_core_checker.sv
`timescale 1ns/1ps

module rv_core_checker (
    input logic clk,
    input logic rst,
    input logic req,
    input logic ack
);

    // ack only rises on a request that was still held
    ack_needs_req: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> $past(req))
        else $error("ack rose while req was low");

    // host let go, ack must be gone two cycles later
    ack_released: assert property (@(posedge clk) disable iff (rst) $fell(req) |-> ##2 !ack)
        else $error("ack still high two cycles after req fell");

    ack_clear_after_rst: assert property (@(posedge clk) $fell(rst) |-> !ack)
        else $error("ack high in the first cycle after reset");

endmodule

bind rv_core rv_core_checker i_checker (
    .clk (clk),
    .rst (rst),
    .req (req),
    .ack (ack)
);

// File: testbench/rv_result_monitor.sv
`timescale 1ns/1ps

module rv_result_monitor (
    input  logic            clk,
    input  logic            rst,
    input  logic            req,
    input  logic            ack,
    input  rv_pkg::result_t result,
    input  rv_pkg::result_t expected,   // entry the host is running
    output int              value_errors,
    output int              protocol_errors,
    output int              retired     // one per ack rise
);

    logic ack_q;   // ack one edge back
    logic req_q;

    task automatic compare_field(input string name, input rv_pkg::data_t exp,
                                 input rv_pkg::data_t got);
        if (exp !== got) begin
            $display("** Error at %0t ns: %s expected %h got %h", $time, name, exp, got);
            value_errors++;
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
            req_q <= 1'b0;
            value_errors    = 0;
            protocol_errors = 0;
            retired         = 0;
        end else begin
            ack_q <= ack;
            req_q <= req;
            if (ack && !ack_q) begin  // result settled on the same edge as ack
                retired++;
                compare_field("result.rd", rv_pkg::data_t'(expected.rd), rv_pkg::data_t'(result.rd));
                compare_field("result.we", rv_pkg::data_t'(expected.we), rv_pkg::data_t'(result.we));
                if (expected.we) compare_field("result.value", expected.value, result.value);
            end
            if (ack_q && !ack && req_q) begin
                $display("ack dropped at %0t ns while req was still high", $time);
                protocol_errors++;
            end
        end
    end

endmodule

// File: testbench/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

    localparam int MUL_STAGES   = 2;
    localparam int RESET_CYCLES = 4;

    typedef struct packed {
        rv_pkg::instr_t  instr;
        rv_pkg::result_t exp;
    } test_t;

    logic            clk;
    logic            rst;
    rv_pkg::instr_t  instr;
    logic            req;
    logic            ack;
    rv_pkg::result_t result;
    rv_pkg::result_t expected;  // what the running entry should retire
    int              value_errors;
    int              protocol_errors;
    int              retired;
    int              hs_errors;
    int              cycles = 0;
    int              limit  = 100000;  // replaced once the table is built
    int              seed;
    test_t           tests [$];

    rv_core #(.MUL_STAGES(MUL_STAGES)) i_dut (
        .clk(clk), .rst(rst), .instr(instr), .req(req), .ack(ack), .result(result)
    );

    rv_result_monitor i_monitor (
        .clk(clk), .rst(rst), .req(req), .ack(ack), .result(result), .expected(expected),
        .value_errors(value_errors), .protocol_errors(protocol_errors), .retired(retired)
    );

    function automatic rv_pkg::instr_t op_imm_word(input logic [2:0] f3, input logic [4:0] rd,
                                                   input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, rv_pkg::OPC_OP_IMM};
    endfunction

    function automatic rv_pkg::instr_t op_reg_word(input logic [6:0] f7, input logic [2:0] f3,
                                                   input logic [4:0] rd, input logic [4:0] rs1,
                                                   input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
    endfunction

    function automatic rv_pkg::instr_t lui_word(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, rv_pkg::OPC_LUI};
    endfunction

    task automatic push_test(input rv_pkg::instr_t i, input logic [4:0] rd,
                             input rv_pkg::data_t value, input logic we);
        test_t t;
        t.instr     = i;
        t.exp.rd    = rd;
        t.exp.value = value;
        t.exp.we    = we;
        tests.push_back(t);
    endtask

    // lui plus addi, upper part rounded so the sign-extended low part lands on v
    task automatic load_reg(input logic [4:0] rd, input rv_pkg::data_t v);
        rv_pkg::data_t up;
        up = v + 32'h800;
        push_test(lui_word(rd, up[31:12]), rd, {up[31:12], 12'b0}, 1'b1);
        push_test(op_imm_word(3'b000, rd, rd, v[11:0]), rd, v, 1'b1);
    endtask

    // random pair into x10/x11, products from 64-bit extended operands
    task automatic push_random_mul();
        rv_pkg::data_t a;
        rv_pkg::data_t b;
        logic [63:0]   sa;
        logic [63:0]   sb;
        logic [63:0]   ua;
        logic [63:0]   ub;
        a  = $random(seed);
        b  = $random(seed);
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ua = {32'b0, a};
        ub = {32'b0, b};
        load_reg(5'd10, a);
        load_reg(5'd11, b);
        push_test(op_reg_word(7'h01, 3'b000, 5'd12, 5'd10, 5'd11), 5'd12, (ua * ub) >> 0, 1'b1);
        push_test(op_reg_word(7'h01, 3'b001, 5'd13, 5'd10, 5'd11), 5'd13, (sa * sb) >> 32, 1'b1);
        push_test(op_reg_word(7'h01, 3'b010, 5'd14, 5'd10, 5'd11), 5'd14, (sa * ub) >> 32, 1'b1);
        push_test(op_reg_word(7'h01, 3'b011, 5'd15, 5'd10, 5'd11), 5'd15, (ua * ub) >> 32, 1'b1);
    endtask

    task automatic build_tests();
        // I-type, x1 = -5 and x2 = 100 feed most of what follows
        push_test(op_imm_word(3'b000, 5'd1, 5'd0, 12'hffb), 5'd1, 32'hffff_fffb, 1'b1);
        push_test(op_imm_word(3'b000, 5'd2, 5'd0, 12'h064), 5'd2, 32'h0000_0064, 1'b1);
        push_test(op_imm_word(3'b000, 5'd3, 5'd1, 12'h800), 5'd3, 32'hffff_f7fb, 1'b1);
        push_test(op_imm_word(3'b100, 5'd4, 5'd2, 12'h0f0), 5'd4, 32'h0000_0094, 1'b1);
        push_test(op_imm_word(3'b110, 5'd5, 5'd2, 12'hf00), 5'd5, 32'hffff_ff64, 1'b1);
        push_test(op_imm_word(3'b111, 5'd6, 5'd1, 12'h07f), 5'd6, 32'h0000_007b, 1'b1);
        push_test(op_imm_word(3'b010, 5'd7, 5'd1, 12'h000), 5'd7, 32'h1, 1'b1);   // slti -5 < 0
        push_test(op_imm_word(3'b010, 5'd8, 5'd2, 12'h032), 5'd8, 32'h0, 1'b1);
        push_test(op_imm_word(3'b011, 5'd9, 5'd2, 12'hfff), 5'd9, 32'h1, 1'b1);   // vs 0xffffffff
        push_test(op_imm_word(3'b011, 5'd10, 5'd1, 12'h005), 5'd10, 32'h0, 1'b1);
        push_test(op_imm_word(3'b001, 5'd11, 5'd2, 12'h004), 5'd11, 32'h0000_0640, 1'b1);
        push_test(op_imm_word(3'b101, 5'd12, 5'd1, 12'h01c), 5'd12, 32'h0000_000f, 1'b1);
        push_test(op_imm_word(3'b101, 5'd13, 5'd1, 12'h401), 5'd13, 32'hffff_fffd, 1'b1); // srai
        // R-type, shift amounts come from x2 whose low 5 bits are 4
        push_test(op_reg_word(7'h00, 3'b000, 5'd14, 5'd1, 5'd2), 5'd14, 32'h0000_005f, 1'b1);
        push_test(op_reg_word(7'h20, 3'b000, 5'd15, 5'd1, 5'd2), 5'd15, 32'hffff_ff97, 1'b1);
        push_test(op_reg_word(7'h00, 3'b001, 5'd16, 5'd12, 5'd2), 5'd16, 32'h0000_00f0, 1'b1);
        push_test(op_reg_word(7'h00, 3'b010, 5'd17, 5'd1, 5'd2), 5'd17, 32'h1, 1'b1);
        push_test(op_reg_word(7'h00, 3'b011, 5'd18, 5'd1, 5'd2), 5'd18, 32'h0, 1'b1);
        push_test(op_reg_word(7'h00, 3'b100, 5'd19, 5'd1, 5'd2), 5'd19, 32'hffff_ff9f, 1'b1);
        push_test(op_reg_word(7'h00, 3'b101, 5'd20, 5'd1, 5'd2), 5'd20, 32'h0fff_ffff, 1'b1);
        push_test(op_reg_word(7'h20, 3'b101, 5'd21, 5'd1, 5'd2), 5'd21, 32'hffff_ffff, 1'b1);
        push_test(op_reg_word(7'h00, 3'b110, 5'd22, 5'd2, 5'd4), 5'd22, 32'h0000_00f4, 1'b1);
        push_test(op_reg_word(7'h00, 3'b111, 5'd23, 5'd1, 5'd5), 5'd23, 32'hffff_ff60, 1'b1);
        // lui and the multiply corner operands
        push_test(lui_word(5'd24, 20'h80000), 5'd24, 32'h8000_0000, 1'b1);
        push_test(lui_word(5'd25, 20'hfffff), 5'd25, 32'hffff_f000, 1'b1);
        push_test(op_imm_word(3'b000, 5'd26, 5'd0, 12'hfff), 5'd26, 32'hffff_ffff, 1'b1);
        push_test(lui_word(5'd27, 20'h80000), 5'd27, 32'h8000_0000, 1'b1);
        push_test(op_imm_word(3'b000, 5'd27, 5'd27, 12'hfff), 5'd27, 32'h7fff_ffff, 1'b1);
        push_test(op_reg_word(7'h01, 3'b000, 5'd28, 5'd24, 5'd26), 5'd28, 32'h8000_0000, 1'b1);
        push_test(op_reg_word(7'h01, 3'b001, 5'd29, 5'd24, 5'd26), 5'd29, 32'h0000_0000, 1'b1);
        push_test(op_reg_word(7'h01, 3'b011, 5'd30, 5'd24, 5'd26), 5'd30, 32'h7fff_ffff, 1'b1);
        push_test(op_reg_word(7'h01, 3'b010, 5'd31, 5'd26, 5'd24), 5'd31, 32'hffff_ffff, 1'b1);
        push_test(op_reg_word(7'h01, 3'b001, 5'd28, 5'd27, 5'd27), 5'd28, 32'h3fff_ffff, 1'b1);
        push_test(op_reg_word(7'h01, 3'b000, 5'd29, 5'd1, 5'd2), 5'd29, 32'hffff_fe0c, 1'b1);
        push_test(op_reg_word(7'h01, 3'b010, 5'd30, 5'd1, 5'd2), 5'd30, 32'hffff_ffff, 1'b1);
        push_test(op_reg_word(7'h01, 3'b011, 5'd31, 5'd26, 5'd26), 5'd31, 32'hffff_fffe, 1'b1);
        // x0 stays zero, illegal encodings leave x2 and x4 alone
        push_test(op_imm_word(3'b000, 5'd0, 5'd2, 12'h007), 5'd0, 32'h0, 1'b1);
        push_test(op_reg_word(7'h00, 3'b000, 5'd9, 5'd0, 5'd2), 5'd9, 32'h0000_0064, 1'b1);
        push_test(op_reg_word(7'h7f, 3'b000, 5'd2, 5'd1, 5'd1), 5'd2, 32'h0, 1'b0);
        push_test(op_reg_word(7'h00, 3'b000, 5'd3, 5'd2, 5'd0), 5'd3, 32'h0000_0064, 1'b1);
        push_test(op_reg_word(7'h01, 3'b100, 5'd4, 5'd1, 5'd2), 5'd4, 32'h0, 1'b0);   // div
        push_test(op_imm_word(3'b000, 5'd5, 5'd4, 12'h000), 5'd5, 32'h0000_0094, 1'b1);
        repeat (4) push_random_mul();
    endtask

    // full four-phase cycle for one entry, inputs move on the falling edge
    // req stays up for hold more cycles after ack, so ack has to wait for the host
    task automatic run_handshake(input test_t t, input int hold);
        @(negedge clk);
        instr    = t.instr;
        expected = t.exp;
        req      = 1'b1;
        while (!ack) @(negedge clk);
        repeat (hold) @(negedge clk);
        req = 1'b0;
        while (ack) @(negedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout, no completion after %0d cycles", cycles);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        int total;
        rst       = 1'b1;
        req       = 1'b0;
        instr     = '0;
        expected  = '0;
        hs_errors = 0;
        seed      = 32'h6b4e752d;
        build_tests();
        limit = tests.size() * (MUL_STAGES + 8) + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (tests[k]) run_handshake(tests[k], k % 3);  // hold of 0 to 2 cycles
        repeat (2) @(posedge clk);
        if (retired != tests.size()) begin
            $display("handshake mismatch: %0d acks for %0d requests", retired, tests.size());
            hs_errors++;
        end
        total = value_errors + protocol_errors + hs_errors;
        $display("%0d tests, %0d value errors, %0d handshake errors", tests.size(),
                 value_errors, protocol_errors + hs_errors);
        if (total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: rv_core.f
src/rv_pkg.sv
src/rv_decode.sv
src/rv_multiply.sv
src/rv_alu.sv
src/rv_regfile.sv
src/rv_core.sv
testbench/rv_core_checker.sv
testbench/rv_result_monitor.sv
testbench/tb_rv_core.sv

// File: Makefile
# Verilator flow for rv_core, every variable can be overridden on the command line

VERILATOR  ?= verilator
TOP        ?= tb_rv_core
FILELIST   ?= rv_core.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
FAIL_MSG   ?= Test failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# a non-zero simulator status or the fail message in the log fails the run
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
